//--- Bender.yml
package:
  name: gba_cart

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gba_cart_pkg.sv
      - hdl/rom_loader.sv
      - hdl/cart_rom_port.sv
      - hdl/video_out.sv
      - hdl/gba_cart_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/sdram_model.sv
      - sim/tb_gba_cart.sv

//--- hdl/cart_rom_port.sv
/*
 * Cartridge fetch FSM and SDRAM port select. A core read becomes two
 * 16-bit reads, high half from the lower address, with the core paused.
 * During a download the loader owns the port.
 */
`timescale 1ns/1ns
`include "gba_cart_macros.svh"

module cart_rom_port (
	input  logic                     clk_sys,
	input  logic                     GBA_RESET,
	input  logic                     ioctl_download, // loader owns port
	input  gba_cart_pkg::mem_req_t   load_req,
	input  logic                     cart_rd,        // level from core
	input  gba_cart_pkg::cart_addr_t cart_addr,      // held while paused
	output gba_cart_pkg::cart_data_t cart_data,
	output logic                     cpu_pause,
	input  logic                     mem_ready,
	input  gba_cart_pkg::mem_data_t  mem_dout,
	output gba_cart_pkg::mem_req_t   mem_req
);

	gba_cart_pkg::fetch_state_t state;

	logic rd_q;    // read issued last cycle
	logic rd_fire; // read issued this cycle
	logic start;   // new core request seen in idle
	logic pend;    // request waiting for the first read
	logic go;      // port free for a read

	logic [`GBA_MEM_ADDR_W-2:0] word_addr; // 16-bit word address of high half
	gba_cart_pkg::mem_data_t    data_hi;
	gba_cart_pkg::mem_data_t    data_lo;
	gba_cart_pkg::mem_addr_t    rd_addr;
	gba_cart_pkg::mem_req_t     fetch_req;

	assign go    = mem_ready && !ioctl_download;
	assign start = cart_rd && !ioctl_download; // no fetch during download
	assign pend  = start || cpu_pause;

	// read strobe is combinational so it always sees mem_ready
	always_comb begin
		rd_fire = 1'b0;
		rd_addr = {cart_addr[`GBA_MEM_ADDR_W-1:1], 1'b0}; // core addr held
		case (state)
			gba_cart_pkg::FETCH_IDLE: begin
				rd_fire = pend && go;
			end
			gba_cart_pkg::FETCH_HI: begin
				rd_fire = go && !rd_q; // one idle cycle between reads
				rd_addr = {word_addr + 1'b1, 1'b0}; // next word
			end
			default: begin
				rd_fire = 1'b0; // low half just waits for data
			end
		endcase
	end

	always_ff @(posedge clk_sys or posedge GBA_RESET) begin
		if (GBA_RESET) begin
			state     <= gba_cart_pkg::FETCH_IDLE;
			cpu_pause <= 1'b0;
			rd_q      <= 1'b0;
		end else begin
			rd_q <= rd_fire;
			case (state)
				gba_cart_pkg::FETCH_IDLE: begin
					if (pend) begin
						cpu_pause <= 1'b1; // hold core until both halves are in
						if (rd_fire) begin
							state <= gba_cart_pkg::FETCH_HI;
						end
					end
				end
				gba_cart_pkg::FETCH_HI: begin
					if (rd_fire) begin
						state <= gba_cart_pkg::FETCH_LO;
					end
				end
				gba_cart_pkg::FETCH_LO: begin
					cpu_pause <= 1'b0; // word complete
					state     <= gba_cart_pkg::FETCH_IDLE;
				end
				default: begin
					state <= gba_cart_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

	// payload capture
	always_ff @(posedge clk_sys) begin
		if (state == gba_cart_pkg::FETCH_IDLE && start) begin
			word_addr <= cart_addr[`GBA_MEM_ADDR_W-1:1];
		end
		if (state == gba_cart_pkg::FETCH_HI) begin
			data_hi <= mem_dout; // lower address, valid until next read
		end
		if (state == gba_cart_pkg::FETCH_LO) begin
			data_lo <= mem_dout;
		end
	end

	assign cart_data = {data_hi, data_lo};

	always_comb begin
		fetch_req.we   = 1'b0;
		fetch_req.rd   = rd_fire;
		fetch_req.addr = rd_addr;
		fetch_req.din  = '0;
		fetch_req.wtbt = `GBA_WTBT_FULL;
	end

	assign mem_req = ioctl_download ? load_req : fetch_req; // port select

	// port rule, whoever owns the port
	a_rd_ready: assert property (@(posedge clk_sys) disable iff (GBA_RESET)
		mem_req.rd |-> mem_ready)
		else $error("cart_rom_port: read issued while sdram not ready");

	a_rd_gap: assert property (@(posedge clk_sys) disable iff (GBA_RESET)
		mem_req.rd |=> !mem_req.rd)
		else $error("cart_rom_port: back-to-back read strobes");

endmodule

//--- hdl/gba_cart_macros.svh
/*
 * Fixed widths and constants of the cartridge ROM wrapper.
 * Included by the package, the RTL and the testbench.
 */
`ifndef GBA_CART_MACROS_SVH
`define GBA_CART_MACROS_SVH

// SDRAM side
`define GBA_MEM_ADDR_W   25 // byte address
`define GBA_MEM_DATA_W   16 // one sdram word
`define GBA_WTBT_FULL    2'b11 // both byte enables

// cartridge bus of the core
`define GBA_CART_ADDR_W  32
`define GBA_CART_DATA_W  32

// video
`define GBA_CHAN_IN_W    5 // core color channel
`define GBA_CHAN_OUT_W   8 // expanded channel
`define GBA_VIDEO_STAGES 2 // pixel pipeline depth in cycles

// display settings
`define GBA_SCALE_W      3 // scaler field of status
`define GBA_ASPECT_W     8
`define GBA_ARX_WIDE     16 // 16:9
`define GBA_ARY_WIDE     9
`define GBA_ARX_STD      4 // 4:3
`define GBA_ARY_STD      3

`endif

//--- hdl/gba_cart_pkg.sv
/*
 * Shared types of the cartridge ROM wrapper: vector widths, the memory
 * request and pixel bundles, and the fetch FSM states.
 */
`include "gba_cart_macros.svh"

package gba_cart_pkg;

	// plain vectors with a meaning
	typedef logic [`GBA_MEM_ADDR_W-1:0]  mem_addr_t;  // sdram byte address
	typedef logic [`GBA_MEM_DATA_W-1:0]  mem_data_t;  // sdram word
	typedef logic [`GBA_CART_ADDR_W-1:0] cart_addr_t; // core byte address
	typedef logic [`GBA_CART_DATA_W-1:0] cart_data_t; // assembled rom word
	typedef logic [`GBA_CHAN_IN_W-1:0]   chan5_t;
	typedef logic [`GBA_CHAN_OUT_W-1:0]  chan8_t;
	typedef logic [`GBA_SCALE_W-1:0]     scale_sel_t; // 0 none, 1 hq2x, 2..4 crt
	typedef logic [`GBA_ASPECT_W-1:0]    aspect_t;

	// one request to the sdram controller port
	typedef struct packed {
		logic      we;   // one-cycle write strobe
		logic      rd;   // one-cycle read strobe
		mem_addr_t addr;
		mem_data_t din;
		logic [1:0] wtbt; // byte enables
	} mem_req_t;

	// pixel straight from the core
	typedef struct packed {
		chan5_t r;
		chan5_t g;
		chan5_t b;
		logic   de;
		logic   hs;
		logic   vs;
		logic   hblank;
		logic   vblank;
	} pix_in_t;

	// blanked and expanded pixel
	typedef struct packed {
		chan8_t r;
		chan8_t g;
		chan8_t b;
		logic   de;
		logic   hs;
		logic   vs;
	} pix_out_t;

	typedef enum logic [1:0] {
		FETCH_IDLE, // waiting for cart_rd
		FETCH_HI,   // high half read in flight
		FETCH_LO    // low half read in flight
	} fetch_state_t;

endpackage

//--- hdl/gba_cart_top.sv
/*
 * Cartridge ROM side of the emulator wrapper. Download into SDRAM,
 * cartridge fetch for the core, and the video output stage.
 */
`timescale 1ns/1ns

module gba_cart_top (
	input  logic                     clk_sys,
	input  logic                     GBA_RESET, // already includes download

	// rom download stream
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  gba_cart_pkg::mem_addr_t  ioctl_addr,
	input  gba_cart_pkg::mem_data_t  ioctl_dout,

	// core cartridge bus
	input  logic                     cart_rd,
	input  gba_cart_pkg::cart_addr_t cart_addr,
	output gba_cart_pkg::cart_data_t cart_data,
	output logic                     cpu_pause,

	// sdram controller port
	input  logic                     mem_ready,
	input  gba_cart_pkg::mem_data_t  mem_dout,
	output gba_cart_pkg::mem_req_t   mem_req,

	// video
	input  gba_cart_pkg::pix_in_t    pix_in,
	input  logic                     status_wide,
	input  gba_cart_pkg::scale_sel_t scale,
	input  logic                     forced_scandoubler,
	output gba_cart_pkg::pix_out_t   pix_out,
	output gba_cart_pkg::aspect_t    video_arx,
	output gba_cart_pkg::aspect_t    video_ary,
	output logic [1:0]               vga_sl,
	output logic                     scandoubler,
	output logic                     hq2x
);

	gba_cart_pkg::mem_req_t load_req; // loader to port select

	rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.GBA_RESET  (GBA_RESET),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.load_req   (load_req)
	);

	cart_rom_port u_cart_rom_port (
		.clk_sys        (clk_sys),
		.GBA_RESET      (GBA_RESET),
		.ioctl_download (ioctl_download),
		.load_req       (load_req),
		.cart_rd        (cart_rd),
		.cart_addr      (cart_addr),
		.cart_data      (cart_data),
		.cpu_pause      (cpu_pause),
		.mem_ready      (mem_ready),
		.mem_dout       (mem_dout),
		.mem_req        (mem_req)
	);

	video_out u_video_out (
		.clk_sys            (clk_sys),
		.GBA_RESET          (GBA_RESET),
		.pix_in             (pix_in),
		.status_wide        (status_wide),
		.scale              (scale),
		.forced_scandoubler (forced_scandoubler),
		.pix_out            (pix_out),
		.video_arx          (video_arx),
		.video_ary          (video_ary),
		.vga_sl             (vga_sl),
		.scandoubler        (scandoubler),
		.hq2x               (hq2x)
	);

endmodule

//--- hdl/rom_loader.sv
/*
 * Download stage. Each ioctl write strobe becomes one full-width SDRAM
 * write request, one cycle later. No ready check on the write.
 */
`timescale 1ns/1ns
`include "gba_cart_macros.svh"

module rom_loader (
	input  logic                    clk_sys,
	input  logic                    GBA_RESET,
	input  logic                    ioctl_wr,   // one-cycle strobe
	input  gba_cart_pkg::mem_addr_t ioctl_addr, // even byte address
	input  gba_cart_pkg::mem_data_t ioctl_dout,
	output gba_cart_pkg::mem_req_t  load_req
);

	logic                    we_q; // delayed strobe
	gba_cart_pkg::mem_addr_t addr_q;
	gba_cart_pkg::mem_data_t din_q;

	// strobe in, strobe out, self clearing
	always_ff @(posedge clk_sys or posedge GBA_RESET) begin
		if (GBA_RESET) begin
			we_q <= 1'b0;
		end else begin
			we_q <= ioctl_wr;
		end
	end

	// address and data only move on a strobe
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			addr_q <= ioctl_addr;
			din_q  <= ioctl_dout;
		end
	end

	always_comb begin
		load_req.we   = we_q;
		load_req.rd   = 1'b0; // loader never reads
		load_req.addr = addr_q;
		load_req.din  = din_q;
		load_req.wtbt = `GBA_WTBT_FULL; // whole word every time
	end

	// every write request lands on an even address
	a_load_even: assert property (@(posedge clk_sys) disable iff (GBA_RESET)
		load_req.we |-> !load_req.addr[0])
		else $error("rom_loader: download write at odd address");

endmodule

//--- hdl/video_out.sv
/*
 * Video stage. Blanks the core pixel outside the display window and
 * expands each channel to 8 bits, two cycles deep. Also registers the
 * aspect and scaler settings decoded from status.
 */
`timescale 1ns/1ns
`include "gba_cart_macros.svh"

module video_out (
	input  logic                     clk_sys,
	input  logic                     GBA_RESET,
	input  gba_cart_pkg::pix_in_t    pix_in,
	input  logic                     status_wide, // aspect bit
	input  gba_cart_pkg::scale_sel_t scale,
	input  logic                     forced_scandoubler,
	output gba_cart_pkg::pix_out_t   pix_out,
	output gba_cart_pkg::aspect_t    video_arx,
	output gba_cart_pkg::aspect_t    video_ary,
	output logic [1:0]               vga_sl,
	output logic                     scandoubler,
	output logic                     hq2x
);

	logic blank;

	gba_cart_pkg::chan5_t s1_r, s1_g, s1_b; // blanked color
	logic s1_de, s1_hs, s1_vs;
	gba_cart_pkg::chan8_t s2_r, s2_g, s2_b; // expanded color
	logic s2_de, s2_hs, s2_vs;

	gba_cart_pkg::scale_sel_t sl; // scanline level before truncation

	// outside active area or in either blanking interval
	assign blank = !pix_in.de || pix_in.hblank || pix_in.vblank;

	// syncs and de
	always_ff @(posedge clk_sys or posedge GBA_RESET) begin
		if (GBA_RESET) begin
			s1_de <= 1'b0;
			s1_hs <= 1'b0;
			s1_vs <= 1'b0;
			s2_de <= 1'b0;
			s2_hs <= 1'b0;
			s2_vs <= 1'b0;
		end else begin
			s1_de <= pix_in.de;
			s1_hs <= pix_in.hs;
			s1_vs <= pix_in.vs;
			s2_de <= s1_de;
			s2_hs <= s1_hs;
			s2_vs <= s1_vs;
		end
	end

	// color path
	always_ff @(posedge clk_sys) begin
		s1_r <= blank ? '0 : pix_in.r;
		s1_g <= blank ? '0 : pix_in.g;
		s1_b <= blank ? '0 : pix_in.b;
		s2_r <= {s1_r, {(`GBA_CHAN_OUT_W-`GBA_CHAN_IN_W){1'b0}}}; // low bits zero
		s2_g <= {s1_g, {(`GBA_CHAN_OUT_W-`GBA_CHAN_IN_W){1'b0}}};
		s2_b <= {s1_b, {(`GBA_CHAN_OUT_W-`GBA_CHAN_IN_W){1'b0}}};
	end

	always_comb begin
		pix_out.r  = s2_r;
		pix_out.g  = s2_g;
		pix_out.b  = s2_b;
		pix_out.de = s2_de;
		pix_out.hs = s2_hs;
		pix_out.vs = s2_vs;
	end

	// 0 none, 1 hq2x, then crt 25/50/75
	assign sl = (scale != '0) ? scale - 1'b1 : '0;

	always_ff @(posedge clk_sys or posedge GBA_RESET) begin
		if (GBA_RESET) begin
			video_arx   <= gba_cart_pkg::aspect_t'(`GBA_ARX_STD);
			video_ary   <= gba_cart_pkg::aspect_t'(`GBA_ARY_STD);
			vga_sl      <= 2'b00;
			scandoubler <= 1'b0;
			hq2x        <= 1'b0;
		end else begin
			video_arx   <= status_wide ? gba_cart_pkg::aspect_t'(`GBA_ARX_WIDE)
			                           : gba_cart_pkg::aspect_t'(`GBA_ARX_STD);
			video_ary   <= status_wide ? gba_cart_pkg::aspect_t'(`GBA_ARY_WIDE)
			                           : gba_cart_pkg::aspect_t'(`GBA_ARY_STD);
			vga_sl      <= sl[1:0];
			scandoubler <= (scale != '0) || forced_scandoubler;
			hq2x        <= (scale == 3'd1);
		end
	end

endmodule

//--- project.f
+incdir+hdl
hdl/gba_cart_pkg.sv
hdl/rom_loader.sv
hdl/cart_rom_port.sv
hdl/video_out.sv
hdl/gba_cart_top.sv
sim/sdram_model.sv
sim/tb_gba_cart.sv

//--- sim/sdram_model.sv
/*
 * Behavioral SDRAM for simulation. Writes land at the clock edge of the
 * request. A read returns its word one cycle after the strobe and holds it.
 */
`timescale 1ns/1ns
`include "gba_cart_macros.svh"

module sdram_model (
	input  logic                    clk_sys,
	input  gba_cart_pkg::mem_req_t  mem_req,
	output gba_cart_pkg::mem_data_t mem_dout
);

	gba_cart_pkg::mem_data_t mem [int unsigned]; // sparse, keyed by word address

	// unwritten words, every address bit moves the pattern
	function automatic gba_cart_pkg::mem_data_t fill_word(input int unsigned w);
		return w[15:0] ^ {w[7:0], w[23:16]} ^ 16'h5aa5;
	endfunction

	initial mem_dout = '0;

	always @(posedge clk_sys) begin : port
		int unsigned             idx;
		gba_cart_pkg::mem_data_t old;
		idx = mem_req.addr[`GBA_MEM_ADDR_W-1:1]; // 16-bit word index
		old = mem.exists(idx) ? mem[idx] : fill_word(idx);
		if (mem_req.we) begin
			mem[idx] = {mem_req.wtbt[1] ? mem_req.din[15:8] : old[15:8],
			            mem_req.wtbt[0] ? mem_req.din[7:0]  : old[7:0]};
		end
		if (mem_req.rd) begin
			mem_dout <= old; // held until the next read
		end
	end

endmodule

//--- sim/tb_gba_cart.sv
/*
 * Testbench for the cartridge ROM wrapper. Downloads a random ROM image,
 * fetches words with and without SDRAM back-pressure, then checks the
 * video pipeline and the display settings decode.
 */
`timescale 1ns/1ns
`include "gba_cart_macros.svh"

module tb_gba_cart;

	localparam int N_LOAD  = 256; // downloaded words
	localparam int N_FETCH = 64;  // fetches per pass
	localparam int N_PIX   = 300;
	localparam int N_SET   = 32;  // scale x aspect x forced
	localparam logic [`GBA_MEM_ADDR_W-1:0] ROM_BASE = 'h400;
	// two cycles per download word, two fetch passes, one cycle per pixel and setting
	localparam int LIMIT = 2 * N_LOAD + 8 * 2 * N_FETCH + N_PIX + `GBA_VIDEO_STAGES
		+ N_SET + 100;

	logic                     clk_sys;
	logic                     GBA_RESET;
	logic                     ioctl_download;
	logic                     ioctl_wr;
	gba_cart_pkg::mem_addr_t  ioctl_addr;
	gba_cart_pkg::mem_data_t  ioctl_dout;
	logic                     cart_rd;
	gba_cart_pkg::cart_addr_t cart_addr;
	gba_cart_pkg::cart_data_t cart_data;
	logic                     cpu_pause;
	logic                     mem_ready;
	gba_cart_pkg::mem_data_t  mem_dout;
	gba_cart_pkg::mem_req_t   mem_req;
	gba_cart_pkg::pix_in_t    pix_in;
	logic                     status_wide;
	gba_cart_pkg::scale_sel_t scale;
	logic                     forced_scandoubler;
	gba_cart_pkg::pix_out_t   pix_out;
	gba_cart_pkg::aspect_t    video_arx;
	gba_cart_pkg::aspect_t    video_ary;
	logic [1:0]               vga_sl;
	logic                     scandoubler;
	logic                     hq2x;

	logic [31:0]             rng = 32'd95; // xorshift state
	gba_cart_pkg::mem_data_t shadow [int unsigned]; // what the rom should hold
	gba_cart_pkg::pix_out_t  exp_pix [$];

	gba_cart_top DUT (.*);

	sdram_model u_sdram (
		.clk_sys  (clk_sys),
		.mem_req  (mem_req),
		.mem_dout (mem_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns
	end

	function logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ready three cycles out of four
	function logic pick_ready();
		logic [31:0] r;
		r = rand32();
		return r[1:0] != 2'b00;
	endfunction

	// halfword aligned, next word still inside the image
	function gba_cart_pkg::cart_addr_t pick_addr();
		logic [31:0] r;
		r = rand32();
		return 32'(ROM_BASE) + 2 * (r % (N_LOAD - 1));
	endfunction

	// high half from the lower address, bit 0 ignored
	function automatic gba_cart_pkg::cart_data_t expect_cart(input gba_cart_pkg::cart_addr_t a);
		int unsigned wa;
		wa = a[`GBA_MEM_ADDR_W-1:1];
		return {shadow[wa], shadow[wa + 1]};
	endfunction

	function automatic gba_cart_pkg::pix_out_t expect_pix(input gba_cart_pkg::pix_in_t p);
		gba_cart_pkg::pix_out_t o;
		logic                   vis;
		vis  = p.de && !p.hblank && !p.vblank; // color only inside the window
		o.r  = vis ? {p.r, 3'b000} : 8'h00;
		o.g  = vis ? {p.g, 3'b000} : 8'h00;
		o.b  = vis ? {p.b, 3'b000} : 8'h00;
		o.de = p.de;
		o.hs = p.hs;
		o.vs = p.vs;
		return o;
	endfunction

	// {arx, ary, vga_sl, scandoubler, hq2x}
	function automatic logic [19:0] expect_settings(input logic wide, input logic [2:0] sc,
		input logic fsd);
		logic [7:0] arx;
		logic [7:0] ary;
		logic [2:0] sl;
		arx = wide ? 8'(`GBA_ARX_WIDE) : 8'(`GBA_ARX_STD);
		ary = wide ? 8'(`GBA_ARY_WIDE) : 8'(`GBA_ARY_STD);
		sl  = (sc == 3'd0) ? 3'd0 : sc - 3'd1;
		return {arx, ary, sl[1:0], (sc != 3'd0) || fsd, sc == 3'd1};
	endfunction

	// outputs settled, inputs change here
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic load_rom();
		logic [31:0]             r;
		gba_cart_pkg::mem_addr_t a;
		ioctl_download = 1'b1;
		for (int i = 0; i < N_LOAD; i++) begin
			r = rand32();
			a = ROM_BASE + 2 * i;
			shadow[a >> 1] = r[15:0];
			ioctl_wr   = 1'b1;
			ioctl_addr = a;
			ioctl_dout = r[15:0];
			step();
			ioctl_wr = 1'b0;
			// write request one cycle behind the strobe
			check_value($sformatf("load %0d we", i), 1, mem_req.we);
			check_value($sformatf("load %0d addr", i), a, mem_req.addr);
			check_value($sformatf("load %0d din", i), r[15:0], mem_req.din);
			check_value($sformatf("load %0d wtbt", i), 2'b11, mem_req.wtbt); // both bytes
			step(); // last write lands here
			check_value($sformatf("load %0d we clear", i), 0, mem_req.we);
		end
		ioctl_download = 1'b0;
	endtask

	task automatic fetch_word(input string name, input gba_cart_pkg::cart_addr_t a,
		input logic random_ready);
		int cycles;
		cart_rd   = 1'b1;
		cart_addr = a; // held until pause falls
		mem_ready = random_ready ? pick_ready() : 1'b1;
		step();
		cart_rd = 1'b0;
		check_value({name, " pause rise"}, 1, cpu_pause);
		cycles = 0;
		while (cpu_pause) begin
			mem_ready = random_ready ? pick_ready() : 1'b1;
			step();
			cycles++;
		end
		check_value({name, " min length"}, 1, cycles >= 3);
		check_value({name, " data"}, expect_cart(a), cart_data);
		mem_ready = 1'b1;
	endtask

	task automatic run_video();
		logic [31:0]            r;
		gba_cart_pkg::pix_in_t  p;
		gba_cart_pkg::pix_out_t e;
		for (int i = 0; i < N_PIX + `GBA_VIDEO_STAGES; i++) begin
			if (i >= `GBA_VIDEO_STAGES) begin
				e = exp_pix.pop_front();
				check_value($sformatf("pixel %0d", i - `GBA_VIDEO_STAGES), e, pix_out);
			end
			if (i < N_PIX) begin
				r = rand32();
				p = gba_cart_pkg::pix_in_t'(r[19:0]);
				pix_in = p;
				exp_pix.push_back(expect_pix(p));
			end else begin
				pix_in = '0; // drain
			end
			step();
		end
	endtask

	task automatic run_settings();
		for (int w = 0; w < 2; w++) begin
			for (int f = 0; f < 2; f++) begin
				for (int s = 0; s < 8; s++) begin
					status_wide        = w[0];
					forced_scandoubler = f[0];
					scale              = s[2:0];
					step(); // registered, one cycle
					check_value($sformatf("settings wide %0d forced %0d scale %0d", w, f, s),
						expect_settings(w[0], s[2:0], f[0]),
						{video_arx, video_ary, vga_sl, scandoubler, hq2x});
				end
			end
		end
	endtask

	initial begin
		repeat (LIMIT) @(posedge clk_sys);
		$display("timeout, run still busy after %0d cycles", LIMIT);
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		GBA_RESET          = 1'b1;
		ioctl_download     = 1'b0;
		ioctl_wr           = 1'b0;
		ioctl_addr         = '0;
		ioctl_dout         = '0;
		cart_rd            = 1'b0;
		cart_addr          = '0;
		mem_ready          = 1'b1;
		pix_in             = '0;
		status_wide        = 1'b0;
		scale              = '0;
		forced_scandoubler = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		GBA_RESET = 1'b0;

		check_value("reset pause", 0, cpu_pause);
		check_value("reset rd", 0, mem_req.rd);
		check_value("reset we", 0, mem_req.we);
		check_value("reset de", 0, pix_out.de);

		load_rom();
		for (int i = 0; i < N_FETCH; i++) begin
			fetch_word($sformatf("fetch %0d", i), pick_addr(), 1'b0);
		end
		// same again under back-pressure
		for (int i = 0; i < N_FETCH; i++) begin
			fetch_word($sformatf("fetch busy %0d", i), pick_addr(), 1'b1);
		end
		run_video();
		run_settings();

		$display("No errors");
		$finish;
	end

endmodule
